/* design/breakout_settings.svh */
`ifndef BREAKOUT_SETTINGS_SVH
`define BREAKOUT_SETTINGS_SVH

// coordinate widths cover a 640x480 screen
`define screenXBits 10
`define screenYBits 9
`define colourBits 3

// brick grid, numbered in rows of brickCols from the top left
`define brickCount 12
`define brickCols 4
`define brickW 120
`define brickH 40
`define brickX0 20
`define brickY0 20
`define brickPitchX 140
`define brickPitchY 60

`define paddleW 80
`define paddleH 20
`define paddleY 440
`define paddleInitX 240

`define ballSize 30
`define ballInitX 305
`define ballInitY 225

`define colourBrick 7
`define colourBlank 0
`define colourPaddle 5
`define colourBall 4

`endif

/* design/breakoutPkg.sv */
`default_nettype none

`include "breakout_settings.svh"

package breakoutPkg;

    // codes 29 to 31 are left unnamed and behave as idle
    typedef enum logic [4:0] {
        codeIdle          = 5'd0,
        codePopulateFirst = 5'd1,
        codePopulateLast  = 5'd12,
        codePaddleErase   = 5'd13,
        codePaddleDraw    = 5'd14,
        codeBallErase     = 5'd15,
        codeBallDraw      = 5'd16,
        codeRemoveFirst   = 5'd17,
        codeRemoveLast    = 5'd28
    } drawCode;

    typedef struct packed {
        logic                     enable;
        logic [`screenXBits-1:0]  x;
        logic [`screenYBits-1:0]  y;
        logic [`colourBits-1:0]   colour;
    } pixelWord;

    typedef struct packed {
        logic [`screenXBits-1:0]  x;
        logic [`screenYBits-1:0]  y;
        logic [`screenXBits-1:0]  width;
        logic [`screenYBits-1:0]  height;
    } rectGeom;

    typedef struct packed {
        logic [`screenXBits-1:0]  x;
        logic [`screenYBits-1:0]  y;
    } point;

    // declared from the top bit down, so the flat bit index equals the draw code minus one
    typedef struct packed {
        logic [`brickCount-1:0]   brickRemove;
        logic                     ballDraw;
        logic                     ballErase;
        logic                     paddleDraw;
        logic                     paddleErase;
        logic [`brickCount-1:0]   brickPopulate;
    } pendingFlags;

    typedef logic [4:0] targetId;

endpackage

`default_nettype wire

/* design/objectSelect.sv */
`timescale 1ns/1ps
`default_nettype none

`include "breakout_settings.svh"

module objectSelect
    import breakoutPkg::*;
(
    input  drawCode                  ld_draw,
    input  pendingFlags              pending,
    input  point                     paddleNow,
    input  point                     paddleOld,
    input  point                     ballNow,
    input  point                     ballOld,
    output logic                     go,
    output targetId                  target,
    output rectGeom                  rect,
    output logic [`colourBits-1:0]   colour
);

    logic [4:0]                 codeValue;
    logic                       isPopulate;
    logic                       isRemove;
    logic                       validCode;
    logic [3:0]                 brickIndex;
    logic [3:0]                 brickCol;
    logic [3:0]                 brickRow;
    rectGeom                    brickRect;
    logic [$bits(pendingFlags)-1:0] pendingBits;

    assign pendingBits = pending;

    always_comb
    begin
        codeValue  = ld_draw;
        isPopulate = (codeValue >= codePopulateFirst) && (codeValue <= codePopulateLast);
        isRemove   = (codeValue >= codeRemoveFirst) && (codeValue <= codeRemoveLast);
        validCode  = (codeValue >= codePopulateFirst) && (codeValue <= codeRemoveLast);

        target = validCode ? targetId'(codeValue - 5'd1) : targetId'(0);

        // populate and remove share the brick geometry
        brickIndex = isRemove ? 4'(codeValue - codeRemoveFirst)
                              : 4'(codeValue - codePopulateFirst);
        brickCol   = 4'(brickIndex % `brickCols);
        brickRow   = 4'(brickIndex / `brickCols);

        brickRect.x      = `screenXBits'(`brickX0 + brickCol * `brickPitchX);
        brickRect.y      = `screenYBits'(`brickY0 + brickRow * `brickPitchY);
        brickRect.width  = `screenXBits'(`brickW);
        brickRect.height = `screenYBits'(`brickH);

        rect   = '0;
        colour = `colourBits'(`colourBlank);

        if (isPopulate)
        begin
            rect   = brickRect;
            colour = `colourBits'(`colourBrick);
        end
        else if (isRemove)
        begin
            rect = brickRect;
        end
        else if (codeValue == codePaddleErase)
        begin
            rect = '{x: paddleOld.x, y: paddleOld.y,
                     width: `screenXBits'(`paddleW), height: `screenYBits'(`paddleH)};
        end
        else if (codeValue == codePaddleDraw)
        begin
            rect   = '{x: paddleNow.x, y: paddleNow.y,
                       width: `screenXBits'(`paddleW), height: `screenYBits'(`paddleH)};
            colour = `colourBits'(`colourPaddle);
        end
        else if (codeValue == codeBallErase)
        begin
            rect = '{x: ballOld.x, y: ballOld.y,
                     width: `screenXBits'(`ballSize), height: `screenYBits'(`ballSize)};
        end
        else if (codeValue == codeBallDraw)
        begin
            rect   = '{x: ballNow.x, y: ballNow.y,
                       width: `screenXBits'(`ballSize), height: `screenYBits'(`ballSize)};
            colour = `colourBits'(`colourBall);
        end

        // an object already drawn since its flag was last set stays quiet
        go = validCode && pendingBits[target];
    end

endmodule

`default_nettype wire

/* design/rectScanner.sv */
`timescale 1ns/1ps
`default_nettype none

`include "breakout_settings.svh"

module rectScanner
    import breakoutPkg::*;
(
    input  logic                     clk,
    input  logic                     ld_resetInitial,
    input  logic                     go,
    input  rectGeom                  rect,
    input  logic [`colourBits-1:0]   colour,
    output pixelWord                 pixel,
    output logic                     done
);

    logic [`screenXBits-1:0]  colCount;
    logic [`screenYBits-1:0]  rowCount;
    logic                     lastCol;
    logic                     lastRow;
    logic                     outEnable;
    point                     outPos;
    logic [`colourBits-1:0]   outColour;

    assign lastCol = (colCount == rect.width - `screenXBits'(1));
    assign lastRow = (rowCount == rect.height - `screenYBits'(1));
    assign done    = go && lastCol && lastRow;

    always_ff @(posedge clk)
    begin
        if (ld_resetInitial)
        begin
            colCount  <= '0;
            rowCount  <= '0;
            outEnable <= 1'b0;
        end
        else
        begin
            outEnable <= go;
            // a dropped go or the last pixel both leave the counters at the origin
            if (!go || done)
            begin
                colCount <= '0;
                rowCount <= '0;
            end
            else if (lastCol)
            begin
                colCount <= '0;
                rowCount <= rowCount + `screenYBits'(1);
            end
            else
            begin
                colCount <= colCount + `screenXBits'(1);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        outPos.x  <= rect.x + colCount;
        outPos.y  <= rect.y + rowCount;
        outColour <= colour;
    end

    assign pixel = '{enable: outEnable, x: outPos.x, y: outPos.y, colour: outColour};

endmodule

`default_nettype wire

/* design/drawStatusRegs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "breakout_settings.svh"

module drawStatusRegs
    import breakoutPkg::*;
(
    input  logic                     clk,
    input  logic                     ld_resetInitial,
    input  logic                     frameStart,
    input  logic                     done,
    input  targetId                  target,
    output pendingFlags              pending,
    output logic [`brickCount-1:0]   brickAlive
);

    // removal targets follow the populates and the four paddle and ball flags
    localparam int removeBase = `brickCount + 4;

    logic [$bits(pendingFlags)-1:0]  pendingBits;
    logic                            isRemoveTarget;
    logic [3:0]                      removeIndex;

    assign isRemoveTarget = (target >= targetId'(removeBase));
    assign removeIndex    = 4'(target - targetId'(removeBase));

    always_ff @(posedge clk)
    begin
        if (ld_resetInitial)
        begin
            pendingBits <= '1;
            brickAlive  <= '1;
        end
        else
        begin
            if (frameStart)
            begin
                pendingBits <= '1;
            end
            else if (done)
            begin
                pendingBits[target] <= 1'b0;
            end

            if (done && isRemoveTarget)
            begin
                brickAlive[removeIndex] <= 1'b0;
            end
        end
    end

    assign pending = pendingFlags'(pendingBits);

endmodule

`default_nettype wire

/* design/objectPositions.sv */
`timescale 1ns/1ps
`default_nettype none

`include "breakout_settings.svh"

module objectPositions
    import breakoutPkg::*;
(
    input  logic                     clk,
    input  logic                     ld_resetInitial,
    input  logic                     ld_movePaddle,
    input  logic                     ld_moveBall,
    input  logic [`screenXBits-1:0]  newPaddleX,
    input  point                     newBall,
    output point                     paddleNow,
    output point                     paddleOld,
    output point                     ballNow,
    output point                     ballOld
);

    logic [`screenXBits-1:0]  paddleX;
    logic [`screenXBits-1:0]  paddleOldX;

    always_ff @(posedge clk)
    begin
        if (ld_resetInitial)
        begin
            paddleX    <= `screenXBits'(`paddleInitX);
            paddleOldX <= `screenXBits'(`paddleInitX);
            ballNow    <= '{x: `screenXBits'(`ballInitX), y: `screenYBits'(`ballInitY)};
            ballOld    <= '{x: `screenXBits'(`ballInitX), y: `screenYBits'(`ballInitY)};
        end
        else
        begin
            if (ld_movePaddle)
            begin
                paddleOldX <= paddleX;
                paddleX    <= newPaddleX;
            end
            if (ld_moveBall)
            begin
                ballOld <= ballNow;
                ballNow <= newBall;
            end
        end
    end

    // the paddle only slides sideways
    assign paddleNow = '{x: paddleX, y: `screenYBits'(`paddleY)};
    assign paddleOld = '{x: paddleOldX, y: `screenYBits'(`paddleY)};

endmodule

`default_nettype wire

/* design/breakoutDatapath.sv */
`timescale 1ns/1ps
`default_nettype none

`include "breakout_settings.svh"

module breakoutDatapath
    import breakoutPkg::*;
(
    input  logic                     clk,
    input  logic                     ld_resetInitial,
    input  drawCode                  ld_draw,
    input  logic                     frameStart,
    input  logic                     ld_movePaddle,
    input  logic                     ld_moveBall,
    input  logic [`screenXBits-1:0]  newPaddleX,
    input  point                     newBall,
    output pixelWord                 pixel,
    output pendingFlags              pending,
    output logic [`brickCount-1:0]   brickAlive
);

    point                    paddleNow;
    point                    paddleOld;
    point                    ballNow;
    point                    ballOld;
    logic                    go;
    logic                    done;
    targetId                 target;
    rectGeom                 rect;
    logic [`colourBits-1:0]  colour;

    objectPositions positions (
        .clk             (clk),
        .ld_resetInitial (ld_resetInitial),
        .ld_movePaddle   (ld_movePaddle),
        .ld_moveBall     (ld_moveBall),
        .newPaddleX      (newPaddleX),
        .newBall         (newBall),
        .paddleNow       (paddleNow),
        .paddleOld       (paddleOld),
        .ballNow         (ballNow),
        .ballOld         (ballOld)
    );

    objectSelect select (
        .ld_draw   (ld_draw),
        .pending   (pending),
        .paddleNow (paddleNow),
        .paddleOld (paddleOld),
        .ballNow   (ballNow),
        .ballOld   (ballOld),
        .go        (go),
        .target    (target),
        .rect      (rect),
        .colour    (colour)
    );

    rectScanner scanner (
        .clk             (clk),
        .ld_resetInitial (ld_resetInitial),
        .go              (go),
        .rect            (rect),
        .colour          (colour),
        .pixel           (pixel),
        .done            (done)
    );

    drawStatusRegs status (
        .clk             (clk),
        .ld_resetInitial (ld_resetInitial),
        .frameStart      (frameStart),
        .done            (done),
        .target          (target),
        .pending         (pending),
        .brickAlive      (brickAlive)
    );

endmodule

`default_nettype wire

/* testbench/clockGen.sv */
`timescale 1ns/1ps
`default_nettype none

module clockGen
(
    output logic clk,
    output logic ld_resetInitial
);

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset drops on a rising edge like every other driven input
    initial
    begin
        ld_resetInitial = 1'b1;
        repeat (16) @(posedge clk);
        ld_resetInitial <= 1'b0;
    end

endmodule

`default_nettype wire

/* testbench/tbBreakoutDatapath.sv */
`timescale 1ns/1ps
`default_nettype none

`include "breakout_settings.svh"

module tbBreakoutDatapath
    import breakoutPkg::*;
();

    localparam int brickPixels = `brickW * `brickH;
    // fifteen brick-sized scans take under 75,000 cycles, so this leaves close to double
    localparam int timeoutCycles = 27 * brickPixels + 400;

    logic clk;
    logic ld_resetInitial;
    drawCode ld_draw;
    logic frameStart;
    logic ld_movePaddle;
    logic ld_moveBall;
    logic [`screenXBits-1:0] newPaddleX;
    point newBall;
    pixelWord pixel;
    pendingFlags pending;
    logic [`brickCount-1:0] brickAlive;
    logic [$bits(pendingFlags)-1:0] pendingBits;

    integer seed = 32'h46ca_789f;
    int cycleCount = 0;
    int pixCount = 0;
    int drawBase = 0;
    int modelX = 0;
    int modelY = 0;
    int modelW = 1;
    int modelColour = 0;
    int rasterIndex;
    int expX;
    int expY;
    int paddleModel = `paddleInitX;
    int paddleOldModel = `paddleInitX;
    int ballXModel = `ballInitX;
    int ballYModel = `ballInitY;
    int ballOldXModel = `ballInitX;
    int ballOldYModel = `ballInitY;
    int aliveModel = (1 << `brickCount) - 1;
    int errorCount = 0;
    int errorsBefore = 0;
    int testsRun = 0;
    int testsFailed = 0;

    clockGen clocks (.clk(clk), .ld_resetInitial(ld_resetInitial));

    breakoutDatapath uut (
        .clk             (clk),
        .ld_resetInitial (ld_resetInitial),
        .ld_draw         (ld_draw),
        .frameStart      (frameStart),
        .ld_movePaddle   (ld_movePaddle),
        .ld_moveBall     (ld_moveBall),
        .newPaddleX      (newPaddleX),
        .newBall         (newBall),
        .pixel           (pixel),
        .pending         (pending),
        .brickAlive      (brickAlive)
    );

    assign pendingBits = pending;

    // expected raster position of the pixel on show with X running fastest
    always_comb
    begin
        rasterIndex = pixCount - drawBase;
        expX = modelX + rasterIndex % modelW;
        expY = modelY + rasterIndex / modelW;
    end

    always @(posedge clk)
    begin
        if (pixel.enable)
        begin
            pixCount <= pixCount + 1;
        end
    end

    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles)
        begin
            $display("timeout, the run did not finish within %0d cycles", timeoutCycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic reportMismatch(input string name, input int expected, input int actual);
        errorCount++;
        $display("FAIL at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
    endtask

    task automatic checkValue(input string name, input int expected, input int actual);
        assert (expected == actual)
        else reportMismatch(name, expected, actual);
    endtask

    pixelXCheck: assert property (@(negedge clk) disable iff (ld_resetInitial)
        (!pixel.enable || int'(pixel.x) == expX))
        else reportMismatch("pixel.x", expX, int'(pixel.x));

    pixelYCheck: assert property (@(negedge clk) disable iff (ld_resetInitial)
        (!pixel.enable || int'(pixel.y) == expY))
        else reportMismatch("pixel.y", expY, int'(pixel.y));

    pixelColourCheck: assert property (@(negedge clk) disable iff (ld_resetInitial)
        (!pixel.enable || int'(pixel.colour) == modelColour))
        else reportMismatch("pixel.colour", modelColour, int'(pixel.colour));

    function automatic int randomBelow(input int limit);
        return int'($unsigned($random(seed)) % limit);
    endfunction

    function automatic int brickOriginX(input int k);
        return `brickX0 + (k % `brickCols) * `brickPitchX;
    endfunction

    function automatic int brickOriginY(input int k);
        return `brickY0 + (k / `brickCols) * `brickPitchY;
    endfunction

    // hold the code until its flag falls, then one idle cycle
    task automatic drawObject(input int code, input int x, input int y, input int w,
                              input int h, input int col);
        int startCount;
        @(posedge clk);
        modelX = x;
        modelY = y;
        modelW = w;
        modelColour = col;
        drawBase = pixCount;
        startCount = pixCount;
        ld_draw <= drawCode'(code);
        @(negedge clk);
        while (pendingBits[5'(code - 1)])
        begin
            @(negedge clk);
        end
        checkValue("pixel.enable at flag fall", 1, int'(pixel.enable));
        checkValue("raster index at flag fall", w * h - 1, pixCount - drawBase);
        @(posedge clk);
        ld_draw <= codeIdle;
        @(negedge clk);
        checkValue("pixel.enable after scan", 0, int'(pixel.enable));
        checkValue("pixel count", w * h, pixCount - startCount);
    endtask

    task automatic holdWithoutDrawing(input int code);
        int startCount;
        @(posedge clk);
        startCount = pixCount;
        ld_draw <= drawCode'(code);
        repeat (8) @(posedge clk);
        ld_draw <= codeIdle;
        @(posedge clk);
        @(negedge clk);
        checkValue("pixel count for a cleared flag", 0, pixCount - startCount);
    endtask

    task automatic movePaddle(input int x);
        @(posedge clk);
        newPaddleX <= `screenXBits'(x);
        ld_movePaddle <= 1'b1;
        @(posedge clk);
        ld_movePaddle <= 1'b0;
        paddleOldModel = paddleModel;
        paddleModel = x;
    endtask

    task automatic moveBall(input int x, input int y);
        @(posedge clk);
        newBall <= '{x: `screenXBits'(x), y: `screenYBits'(y)};
        ld_moveBall <= 1'b1;
        @(posedge clk);
        ld_moveBall <= 1'b0;
        ballOldXModel = ballXModel;
        ballOldYModel = ballYModel;
        ballXModel = x;
        ballYModel = y;
    endtask

    task automatic pulseFrameStart();
        @(posedge clk);
        frameStart <= 1'b1;
        @(posedge clk);
        frameStart <= 1'b0;
        @(negedge clk);
        checkValue("pending after frameStart", (1 << 28) - 1, int'(pendingBits));
        checkValue("brickAlive after frameStart", aliveModel, int'(brickAlive));
    endtask

    task automatic removeBrick(input int k);
        drawObject(17 + k, brickOriginX(k), brickOriginY(k), `brickW, `brickH, `colourBlank);
        aliveModel = aliveModel & ~(1 << k);
        checkValue("brickAlive after removal", aliveModel, int'(brickAlive));
        holdWithoutDrawing(17 + k);
    endtask

    task automatic finishTest(input string name);
        testsRun++;
        if (errorCount > errorsBefore)
        begin
            testsFailed++;
            $display("test %0d, %s, failed", testsRun, name);
        end
        else
        begin
            $display("test %0d, %s, passed", testsRun, name);
        end
        errorsBefore = errorCount;
    endtask

    initial
    begin
        ld_draw <= codeIdle;
        frameStart <= 1'b0;
        ld_movePaddle <= 1'b0;
        ld_moveBall <= 1'b0;
        newPaddleX <= '0;
        newBall <= '0;
        @(posedge clk);
        while (ld_resetInitial)
        begin
            @(posedge clk);
        end
        @(negedge clk);
        checkValue("pixel.enable after reset", 0, int'(pixel.enable));
        checkValue("pending after reset", (1 << 28) - 1, int'(pendingBits));
        checkValue("brickAlive after reset", aliveModel, int'(brickAlive));
        drawObject(14, `paddleInitX, `paddleY, `paddleW, `paddleH, `colourPaddle);
        finishTest("reset state and first paddle draw");

        for (int k = 0; k < `brickCount; k++)
        begin
            drawObject(1 + k, brickOriginX(k), brickOriginY(k), `brickW, `brickH, `colourBrick);
        end
        finishTest("populate all bricks");

        pulseFrameStart();
        movePaddle(randomBelow(640 - `paddleW + 1));
        drawObject(13, paddleOldModel, `paddleY, `paddleW, `paddleH, `colourBlank);
        drawObject(14, paddleModel, `paddleY, `paddleW, `paddleH, `colourPaddle);
        finishTest("paddle move, erase and draw");

        moveBall(randomBelow(640 - `ballSize + 1), randomBelow(480 - `ballSize + 1));
        drawObject(15, ballOldXModel, ballOldYModel, `ballSize, `ballSize, `colourBlank);
        drawObject(16, ballXModel, ballYModel, `ballSize, `ballSize, `colourBall);
        finishTest("ball move, erase and draw");

        removeBrick(4);
        removeBrick(9);
        finishTest("brick removal");

        pulseFrameStart();
        drawObject(1, brickOriginX(0), brickOriginY(0), `brickW, `brickH, `colourBrick);
        finishTest("frameStart and populate again");

        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 testsRun, testsFailed, errorCount);
        if (errorCount == 0)
        begin
            $display("TEST RESULT: PASS");
        end
        else
        begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+design
design/breakoutPkg.sv
design/objectSelect.sv
design/rectScanner.sv
design/drawStatusRegs.sv
design/objectPositions.sv
design/breakoutDatapath.sv
testbench/clockGen.sv
testbench/tbBreakoutDatapath.sv

/* run.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log
set -u
cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --assert -f tb.f --top-module tbBreakoutDatapath -o simv
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/simv | tee "$logFile"
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
    echo "simulation did not run to completion"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" "$logFile"; then
    exit 1
fi

if ! grep -q "TEST RESULT: PASS" "$logFile"; then
    echo "no result line in $logFile"
    exit 1
fi
exit 0
